/* hw/row_accum_pkg.sv */
package row_accum_pkg;

    // ------------------------------
    // Widths and bank geometry
    // ------------------------------

    // Partial product value, wraps on overflow
    localparam int VAL_W      = 32;
    localparam int ROW_W      = 16;
    // Column splits into bank and slot
    localparam int COL_W      = 8;

    localparam int NBANK      = 4;
    localparam int BANK_DEPTH = 64;
    localparam int BANK_W     = 2;
    localparam int SLOT_W     = 6;

    // ------------------------------
    // Types
    // ------------------------------

    typedef logic [VAL_W-1:0]  val_t;
    typedef logic [ROW_W-1:0]  row_t;

    // Upper BANK_W bits pick the bank, lower SLOT_W bits the slot
    typedef logic [COL_W-1:0]  col_t;

    typedef logic [BANK_W-1:0] bank_t;
    typedef logic [SLOT_W-1:0] slot_t;

    // One occupancy bit per slot of a bank
    typedef logic [BANK_DEPTH-1:0] bitmap_t;

    // Input side states
    // FILL accepts elements, START kicks the merge, MERGE waits for it
    typedef enum logic [1:0] {
        FILL  = 2'd0,
        START = 2'd1,
        MERGE = 2'd2
    } fill_state_t;

endpackage

/* hw/accum_write_if.sv */
`timescale 1ns/1ps

interface accum_write_if;

    // Write strobe, one element per cycle at most
    logic                 wr_en;
    // Target column, bank in the upper bits
    row_accum_pkg::col_t  wr_col;
    // Value to insert or add
    row_accum_pkg::val_t  wr_val;

    // Input side drives the writes
    modport fill (
        output wr_en,
        output wr_col,
        output wr_val
    );

    // Bank store always takes them
    modport store (
        input  wr_en,
        input  wr_col,
        input  wr_val
    );

endinterface

/* hw/accum_read_if.sv */
`timescale 1ns/1ps

interface accum_read_if;

    // Occupancy of every bank, straight from the store
    row_accum_pkg::bitmap_t  bitmap [row_accum_pkg::NBANK];
    // Slot the merge is looking at
    row_accum_pkg::col_t     rd_col;
    // Combinational read of that slot
    row_accum_pkg::val_t     rd_val;
    // Drop the occupancy bit of rd_col at the next edge
    logic                    clr_en;

    // Store side
    modport store (
        output bitmap,
        output rd_val,
        input  rd_col,
        input  clr_en
    );

    // Merge side
    modport merge (
        input  bitmap,
        input  rd_val,
        output rd_col,
        output clr_en
    );

endinterface

/* hw/row_fill_ctrl.sv */
`timescale 1ns/1ps

module row_fill_ctrl (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 in_valid,
    output logic                 in_ready,
    input  row_accum_pkg::row_t  in_row,
    input  row_accum_pkg::col_t  in_col,
    input  row_accum_pkg::val_t  in_val,
    input  logic                 in_last,
    accum_write_if.fill          wr,
    output logic                 merge_start,
    input  logic                 merge_done
);

    row_accum_pkg::fill_state_t state;
    row_accum_pkg::row_t        cur_row;
    // Set while no element of the current row has been taken
    logic                       first;
    logic                       row_change;
    logic                       accept;

    // ------------------------------
    // Handshake and writes
    // ------------------------------

    // Different row waits outside until the merge is through
    assign row_change = !first && (in_row != cur_row);

    assign in_ready = (state == row_accum_pkg::FILL) && in_valid && !row_change;
    assign accept   = in_valid && in_ready;

    // Accepted element goes to the store in the same cycle
    assign wr.wr_en  = accept;
    assign wr.wr_col = in_col;
    assign wr.wr_val = in_val;

    // One cycle kick for the output side
    assign merge_start = (state == row_accum_pkg::START);

    // ------------------------------
    // Row tracking and FSM
    // ------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= row_accum_pkg::FILL;
            cur_row <= '0;
            first   <= 1'b1;
        end else begin
            case (state)
                row_accum_pkg::FILL: begin
                    if (accept) begin
                        cur_row <= in_row;
                        first   <= 1'b0;
                    end
                    // Row ends on a tagged last element or on a new row showing up
                    if ((accept && in_last) || (in_valid && row_change)) begin
                        state <= row_accum_pkg::START;
                    end
                end
                row_accum_pkg::START: begin
                    state <= row_accum_pkg::MERGE;
                end
                row_accum_pkg::MERGE: begin
                    if (merge_done) begin
                        state <= row_accum_pkg::FILL;
                        // Next element opens a fresh row
                        first <= 1'b1;
                    end
                end
                default: begin
                    state <= row_accum_pkg::FILL;
                end
            endcase
        end
    end

    // Merge may only finish a row that this side handed over
    a_done_in_merge: assert property (
        @(posedge clk) disable iff (!rst_n)
        merge_done |-> (state == row_accum_pkg::MERGE)
    );

endmodule

/* hw/accum_bank_store.sv */
`timescale 1ns/1ps

module accum_bank_store (
    input  logic          clk,
    input  logic          rst_n,
    accum_write_if.store  wr,
    accum_read_if.store   rd
);

    // Values addressed directly by column
    row_accum_pkg::val_t     mem  [row_accum_pkg::NBANK][row_accum_pkg::BANK_DEPTH];
    // Occupancy, the only record of which slots hold data
    row_accum_pkg::bitmap_t  bits [row_accum_pkg::NBANK];

    row_accum_pkg::bank_t    wr_bank;
    row_accum_pkg::slot_t    wr_slot;
    row_accum_pkg::bank_t    rd_bank;
    row_accum_pkg::slot_t    rd_slot;
    logic                    occupied;
    row_accum_pkg::val_t     sum;

    // ------------------------------
    // Address split
    // ------------------------------

    assign wr_bank = wr.wr_col[row_accum_pkg::COL_W-1:row_accum_pkg::SLOT_W];
    assign wr_slot = wr.wr_col[row_accum_pkg::SLOT_W-1:0];
    assign rd_bank = rd.rd_col[row_accum_pkg::COL_W-1:row_accum_pkg::SLOT_W];
    assign rd_slot = rd.rd_col[row_accum_pkg::SLOT_W-1:0];

    // Slot already written in this row
    assign occupied = bits[wr_bank][wr_slot];

    // 32-bit add, carry out is dropped
    assign sum = mem[wr_bank][wr_slot] + wr.wr_val;

    // ------------------------------
    // Value memory
    // ------------------------------

    always_ff @(posedge clk) begin
        if (wr.wr_en) begin
            // First hit overwrites whatever a previous row left behind
            mem[wr_bank][wr_slot] <= occupied ? sum : wr.wr_val;
        end
    end

    // ------------------------------
    // Occupancy bitmaps
    // ------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int b = 0; b < row_accum_pkg::NBANK; b++) begin
                bits[b] <= '0;
            end
        end else begin
            if (wr.wr_en) begin
                bits[wr_bank][wr_slot] <= 1'b1;
            end
            // Emitted slot drops out, its value stays as stale data
            if (rd.clr_en) begin
                bits[rd_bank][rd_slot] <= 1'b0;
            end
        end
    end

    assign rd.bitmap = bits;
    assign rd.rd_val = mem[rd_bank][rd_slot];

    // Fill and merge never touch the same slot together
    a_no_wr_clr_clash: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(wr.wr_en && rd.clr_en && (wr.wr_col == rd.rd_col))
    );

endmodule

/* hw/sorted_merge_out.sv */
`timescale 1ns/1ps

module sorted_merge_out (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 merge_start,
    output logic                 merge_done,
    accum_read_if.merge          rd,
    output logic                 out_valid,
    input  logic                 out_ready,
    output row_accum_pkg::val_t  out_val,
    output row_accum_pkg::col_t  out_col,
    output logic                 out_last,
    output logic                 row_done
);

    logic                    active;
    row_accum_pkg::bank_t    bank_ptr;
    // High for one cycle after the final transfer of a row
    logic                    done_q;

    row_accum_pkg::bitmap_t  cur_bits;
    row_accum_pkg::slot_t    slot;
    logic                    has_bits;
    logic                    only_bit;
    logic                    higher_busy;
    logic                    last_bank;
    logic                    xfer;

    // Lowest set bit, so slots leave in ascending order
    function automatic row_accum_pkg::slot_t lowest_set(input row_accum_pkg::bitmap_t b);
        row_accum_pkg::slot_t idx;
        idx = '0;
        for (int i = row_accum_pkg::BANK_DEPTH - 1; i >= 0; i--) begin
            if (b[i]) begin
                idx = row_accum_pkg::slot_t'(i);
            end
        end
        return idx;
    endfunction

    // ------------------------------
    // Bitmap scan
    // ------------------------------

    assign cur_bits  = rd.bitmap[bank_ptr];
    assign has_bits  = |cur_bits;
    assign slot      = lowest_set(cur_bits);
    // Clearing the lowest bit leaves nothing behind
    assign only_bit  = ((cur_bits & (cur_bits - row_accum_pkg::bitmap_t'(1))) == '0);
    assign last_bank = (bank_ptr == row_accum_pkg::bank_t'(row_accum_pkg::NBANK - 1));

    always_comb begin
        higher_busy = 1'b0;
        for (int b = 0; b < row_accum_pkg::NBANK; b++) begin
            if ((b > int'(bank_ptr)) && (rd.bitmap[b] != '0)) begin
                higher_busy = 1'b1;
            end
        end
    end

    // ------------------------------
    // Output stream
    // ------------------------------

    assign out_valid = active && has_bits;
    assign out_col   = {bank_ptr, slot};
    assign out_val   = rd.rd_val;
    assign out_last  = out_valid && only_bit && !higher_busy;
    assign rd.rd_col = out_col;

    assign xfer      = out_valid && out_ready;
    assign rd.clr_en = xfer;

    assign merge_done = done_q;
    assign row_done   = done_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active   <= 1'b0;
            bank_ptr <= '0;
            done_q   <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (merge_start) begin
                active   <= 1'b1;
                bank_ptr <= '0;
            end else if (active) begin
                if (xfer && out_last) begin
                    active <= 1'b0;
                    done_q <= 1'b1;
                end else if (!has_bits) begin
                    // Empty bank, one cycle to step past it
                    if (last_bank) begin
                        active <= 1'b0;
                        done_q <= 1'b1;
                    end else begin
                        bank_ptr <= bank_ptr + row_accum_pkg::bank_t'(1);
                    end
                end
            end
        end
    end

    // Stalled entry holds until the sink takes it
    a_out_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_col) && $stable(out_val))
    );

endmodule

/* hw/row_accum_top.sv */
`timescale 1ns/1ps

module row_accum_top (
    input  logic                 clk,
    input  logic                 rst_n,
    // Partial product stream
    input  logic                 in_valid,
    output logic                 in_ready,
    input  row_accum_pkg::val_t  in_val,
    input  row_accum_pkg::row_t  in_row,
    input  row_accum_pkg::col_t  in_col,
    input  logic                 in_last,
    // Sorted row output
    output logic                 out_valid,
    input  logic                 out_ready,
    output row_accum_pkg::val_t  out_val,
    output row_accum_pkg::col_t  out_col,
    output logic                 out_last,
    output logic                 row_done
);

    // Handoff between input and output side
    logic merge_start;
    logic merge_done;

    accum_write_if u_wr_if ();
    accum_read_if  u_rd_if ();

    // ------------------------------
    // Input side
    // ------------------------------
    row_fill_ctrl u_fill (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .in_row      (in_row),
        .in_col      (in_col),
        .in_val      (in_val),
        .in_last     (in_last),
        .wr          (u_wr_if.fill),
        .merge_start (merge_start),
        .merge_done  (merge_done)
    );

    // Banks and adder
    accum_bank_store u_store (
        .clk   (clk),
        .rst_n (rst_n),
        .wr    (u_wr_if.store),
        .rd    (u_rd_if.store)
    );

    // ------------------------------
    // Output side
    // ------------------------------
    sorted_merge_out u_merge (
        .clk         (clk),
        .rst_n       (rst_n),
        .merge_start (merge_start),
        .merge_done  (merge_done),
        .rd          (u_rd_if.merge),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_val     (out_val),
        .out_col     (out_col),
        .out_last    (out_last),
        .row_done    (row_done)
    );

endmodule

/* dv/row_accum_tb_table.svh */
`ifndef ROW_ACCUM_TB_TABLE_SVH
`define ROW_ACCUM_TB_TABLE_SVH

// One partial product as the driver presents it
typedef struct packed {
    row_accum_pkg::row_t row;
    row_accum_pkg::col_t col;
    row_accum_pkg::val_t val;
    logic                last;
} elem_t;

localparam int N_ELEM = 36;

// Columns: row, column, value, last flag
localparam elem_t STIM_TABLE [N_ELEM] = '{
    // Row 3, adjacent repeat on col 5, ends on row change
    '{16'd3,  8'd5,   32'h0000_0011, 1'b0},
    '{16'd3,  8'd5,   32'h0000_0022, 1'b0},
    '{16'd3,  8'd200, 32'h0000_1000, 1'b0},
    '{16'd3,  8'd64,  32'h0000_0007, 1'b0},
    '{16'd3,  8'd5,   32'h0000_0100, 1'b0},
    '{16'd3,  8'd130, 32'hdead_beef, 1'b0},
    // Row 7, edge columns and a sum past 32 bits
    '{16'd7,  8'd255, 32'h0000_0001, 1'b0},
    '{16'd7,  8'd0,   32'h0000_002a, 1'b0},
    '{16'd7,  8'd100, 32'hffff_fff0, 1'b0},
    '{16'd7,  8'd255, 32'h0000_0002, 1'b0},
    '{16'd7,  8'd100, 32'h0000_0020, 1'b0},
    '{16'd7,  8'd5,   32'h0000_0005, 1'b0},
    '{16'd7,  8'd100, 32'h8000_0000, 1'b0},
    // Row 9, bank borders, closed by in_last
    '{16'd9,  8'd63,  32'h0000_0003, 1'b0},
    '{16'd9,  8'd192, 32'h0000_0004, 1'b0},
    '{16'd9,  8'd64,  32'h0000_0005, 1'b0},
    '{16'd9,  8'd191, 32'h0000_0006, 1'b0},
    '{16'd9,  8'd63,  32'hffff_ffff, 1'b0},
    '{16'd9,  8'd128, 32'h0000_0009, 1'b1},
    // Same row number again, single element row
    '{16'd9,  8'd0,   32'h1234_5678, 1'b1},
    // Row 12, top bank only
    '{16'd12, 8'd250, 32'h0000_0010, 1'b0},
    '{16'd12, 8'd193, 32'h0000_0020, 1'b0},
    '{16'd12, 8'd250, 32'h0000_0030, 1'b0},
    '{16'd12, 8'd250, 32'h0000_0040, 1'b0},
    // Row 13 reuses col 250 with a fresh value
    '{16'd13, 8'd3,   32'h0000_0001, 1'b0},
    '{16'd13, 8'd250, 32'h0000_0077, 1'b0},
    '{16'd13, 8'd1,   32'h0000_0002, 1'b0},
    '{16'd13, 8'd2,   32'h0000_0003, 1'b0},
    '{16'd13, 8'd1,   32'h0000_0004, 1'b1},
    // Row 20, col 127 wraps to zero
    '{16'd20, 8'd255, 32'ha5a5_a5a5, 1'b0},
    '{16'd20, 8'd0,   32'h5a5a_5a5a, 1'b0},
    '{16'd20, 8'd127, 32'hffff_0000, 1'b0},
    '{16'd20, 8'd128, 32'h0001_0000, 1'b0},
    '{16'd20, 8'd127, 32'h0001_0000, 1'b0},
    // Row 21, final row
    '{16'd21, 8'd66,  32'h0000_0066, 1'b0},
    '{16'd21, 8'd66,  32'h0000_0066, 1'b1}
};

`endif

/* dv/row_accum_tb.sv */
`timescale 1ns/1ps

module row_accum_tb;

    `include "row_accum_tb_table.svh"

    localparam int ACCEPT_TIMEOUT = 1000;
    localparam int DRAIN_TIMEOUT  = 2000;
    localparam int IDLE_CYCLES    = 50;

    logic                clk;
    logic                rst_n;
    logic                in_valid;
    logic                in_ready;
    row_accum_pkg::val_t in_val;
    row_accum_pkg::row_t in_row;
    row_accum_pkg::col_t in_col;
    logic                in_last;
    logic                out_valid;
    logic                out_ready;
    row_accum_pkg::val_t out_val;
    row_accum_pkg::col_t out_col;
    logic                out_last;
    logic                row_done;

    // Expected output stream, in order
    row_accum_pkg::col_t exp_col [$];
    row_accum_pkg::val_t exp_val [$];
    logic                exp_last [$];

    int errors;
    int transfers;
    int rows_seen;
    int rows_expected;

    // Last stalled entry, must still be there one cycle on
    logic                hold;
    row_accum_pkg::col_t held_col;
    row_accum_pkg::val_t held_val;

    row_accum_top u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_val    (in_val),
        .in_row    (in_row),
        .in_col    (in_col),
        .in_last   (in_last),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_val   (out_val),
        .out_col   (out_col),
        .out_last  (out_last),
        .row_done  (row_done)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // ------------------------------
    // Helpers
    // ------------------------------

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
            errors++;
        end
    endtask

    // Sum per column inside each row, then emit in ascending column order
    task automatic build_expected();
        row_accum_pkg::val_t sums [256];
        bit                  used [256];
        bit                  row_end;
        int                  hi;
        for (int c = 0; c < 256; c++) begin
            used[c] = 1'b0;
        end
        for (int i = 0; i < N_ELEM; i++) begin
            if (used[STIM_TABLE[i].col]) begin
                sums[STIM_TABLE[i].col] = sums[STIM_TABLE[i].col] + STIM_TABLE[i].val;
            end else begin
                sums[STIM_TABLE[i].col] = STIM_TABLE[i].val;
                used[STIM_TABLE[i].col] = 1'b1;
            end
            // Row closes on in_last, on a row change or at the end of the table
            row_end = (i == N_ELEM - 1) || STIM_TABLE[i].last ||
                      (STIM_TABLE[i+1].row != STIM_TABLE[i].row);
            if (row_end) begin
                hi = 0;
                for (int c = 0; c < 256; c++) begin
                    if (used[c]) hi = c;
                end
                for (int c = 0; c < 256; c++) begin
                    if (used[c]) begin
                        exp_col.push_back(row_accum_pkg::col_t'(c));
                        exp_val.push_back(sums[c]);
                        exp_last.push_back(c == hi);
                        used[c] = 1'b0;
                    end
                end
                rows_expected++;
            end
        end
    endtask

    // Present one element and hold it until the DUT takes it
    task automatic send_element(input elem_t e, output bit ok);
        int waited;
        waited   = 0;
        ok       = 1'b0;
        in_valid = 1'b1;
        in_row   = e.row;
        in_col   = e.col;
        in_val   = e.val;
        in_last  = e.last;
        while (!ok && waited < ACCEPT_TIMEOUT) begin
            @(negedge clk);
            if (in_ready) ok = 1'b1;
            @(posedge clk);
            #2;
            waited++;
        end
    endtask

    // ------------------------------
    // Sink and monitor
    // ------------------------------

    // Random back-pressure from a fixed seed
    initial begin
        int seed_val;
        out_ready = 1'b0;
        seed_val  = $urandom(32'hdf54);
        forever begin
            @(posedge clk);
            #2;
            out_ready = (($urandom % 3) != 0);
        end
    end

    always @(negedge clk) begin
        if (rst_n) begin
            if (row_done) rows_seen++;
            if (hold) begin
                check_value("out_valid", out_valid, 32'd1);
                check_value("out_col", out_col, held_col);
                check_value("out_val", out_val, held_val);
            end
            hold     = out_valid && !out_ready;
            held_col = out_col;
            held_val = out_val;
            if (out_valid && out_ready) begin
                transfers++;
                if (exp_col.size() == 0) begin
                    $display("Unexpected output at %0t, col 0x%0h with nothing left to expect",
                             $time, out_col);
                    errors++;
                end else begin
                    check_value("out_col", out_col, exp_col.pop_front());
                    check_value("out_val", out_val, exp_val.pop_front());
                    check_value("out_last", out_last, exp_last.pop_front());
                end
            end
        end
    end

    // ------------------------------
    // Main sequence
    // ------------------------------

    initial begin
        int  waited;
        bit  ok;
        bit  timed_out;
        errors        = 0;
        transfers     = 0;
        rows_seen     = 0;
        rows_expected = 0;
        timed_out     = 1'b0;
        hold          = 1'b0;
        rst_n         = 1'b0;
        in_valid      = 1'b0;
        in_row        = '0;
        in_col        = '0;
        in_val        = '0;
        in_last       = 1'b0;
        build_expected();

        repeat (10) @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(posedge clk);
        #2;

        for (int i = 0; i < N_ELEM; i++) begin
            send_element(STIM_TABLE[i], ok);
            if (!ok) begin
                $display("Timeout: element %0d was never accepted", i);
                errors++;
                timed_out = 1'b1;
                break;
            end
        end
        in_valid = 1'b0;
        in_last  = 1'b0;

        // Drain the last rows
        if (!timed_out) begin
            waited = 0;
            while ((exp_col.size() != 0 || rows_seen != rows_expected) &&
                   waited < DRAIN_TIMEOUT) begin
                @(posedge clk);
                waited++;
            end
            if (waited >= DRAIN_TIMEOUT) begin
                $display("Timeout: %0d entries still missing at the output", exp_col.size());
                errors++;
                timed_out = 1'b1;
            end
        end

        // Nothing may come out without new input
        if (!timed_out) begin
            waited = 0;
            while (waited < IDLE_CYCLES) begin
                @(negedge clk);
                check_value("out_valid", out_valid, 32'd0);
                waited++;
            end
            check_value("row_done count", rows_seen, rows_expected);
        end

        $display("Errors: %0d, transfers: %0d, rows: %0d", errors, transfers, rows_seen);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* compile.f */
+incdir+dv
hw/row_accum_pkg.sv
hw/accum_write_if.sv
hw/accum_read_if.sv
hw/row_fill_ctrl.sv
hw/accum_bank_store.sv
hw/sorted_merge_out.sv
hw/row_accum_top.sv
dv/row_accum_tb.sv

/* Bender.yml */
package:
  name: row_accum

sources:
  - hw/row_accum_pkg.sv
  - hw/accum_write_if.sv
  - hw/accum_read_if.sv
  - hw/row_fill_ctrl.sv
  - hw/accum_bank_store.sv
  - hw/sorted_merge_out.sv
  - hw/row_accum_top.sv
  - target: simulation
    include_dirs:
      - dv
    files:
      - dv/row_accum_tb.sv
